//--- ddr_bridge_config.svh
// Width, depth and credit definitions shared by the DDR4 host bridge
`ifndef DDR_BRIDGE_CONFIG_SVH
`define DDR_BRIDGE_CONFIG_SVH

// ******************************
// Application interface widths
// ******************************
`define DDR_APP_ADDR_WIDTH 28
`define DDR_APP_DATA_WIDTH 64

// ******************************
// Queue depths and credits
// ******************************
// Request queue depth, also the host's starting request credits
`define DDR_REQ_DEPTH      8
`define DDR_RD_BUF_DEPTH   8
// Response credits held by the bridge after reset
`define DDR_RSP_CREDITS    4

`endif

//--- ddr_bridge_pkg.sv
// Bridge types: address, data and command vectors, command codes and
// sequencer state encoding
`include "ddr_bridge_config.svh"

package ddr_bridge_pkg;

  // ******************************
  // Application interface vectors
  // ******************************
  typedef logic [`DDR_APP_ADDR_WIDTH-1:0] app_addr_t;
  typedef logic [`DDR_APP_DATA_WIDTH-1:0] app_data_t;

  // Controller command code
  typedef logic [2:0] app_cmd_t;

  localparam app_cmd_t app_cmd_write = 3'b000;
  localparam app_cmd_t app_cmd_read  = 3'b001;

  // ******************************
  // Sequencer FSM
  // ******************************
  typedef enum logic [1:0] {
    wait_calib = 2'd0,
    idle       = 2'd1,
    issue      = 2'd2,
    done_pop   = 2'd3
  } seq_state_t;

endpackage

//--- req_queue.sv
// Host request FIFO with one credit pulse per popped entry
`include "ddr_bridge_config.svh"

module req_queue #(
  parameter int DEPTH = `DDR_REQ_DEPTH
) (
  input  logic                  c0_ddr4_clk,
  input  logic                  reset_i,
  // Host side
  input  logic                  req_valid_i,
  input  logic                  req_write_i,
  input  ddr_bridge_pkg::app_addr_t req_addr_i,
  input  ddr_bridge_pkg::app_data_t req_wdata_i,
  // Sequencer side
  input  logic                  pop_i,
  output logic                  head_valid_o,
  output logic                  head_write_o,
  output ddr_bridge_pkg::app_addr_t head_addr_o,
  output ddr_bridge_pkg::app_data_t head_wdata_o,
  // Credit back to the host
  output logic                  req_credit_o
);

  import ddr_bridge_pkg::*;

  localparam int ptr_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [ptr_width:0]   count_q;

  logic      write_mem [DEPTH];
  app_addr_t addr_mem  [DEPTH];
  app_data_t wdata_mem [DEPTH];

  logic do_push;
  logic do_pop;

  // Wrap at DEPTH so that non power of two depths also work
  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Host obeys the credit rule, so a push never finds the queue full
  assign do_push = req_valid_i;
  assign do_pop  = pop_i && (count_q != '0);

  // ******************************
  // Pointers, occupancy, credit
  // ******************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Slot freed by this pop is returned one cycle later
      req_credit_o <= do_pop;
    end
  end

  // Storage
  always_ff @(posedge c0_ddr4_clk) begin
    if (do_push) begin
      write_mem[wr_ptr_q] <= req_write_i;
      addr_mem[wr_ptr_q]  <= req_addr_i;
      wdata_mem[wr_ptr_q] <= req_wdata_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_write_o = write_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_wdata_o = wdata_mem[rd_ptr_q];

endmodule

//--- app_cmd_sequencer.sv
// Command sequencer FSM for the DDR4 application interface, with the
// read-return slot reservation counter
`include "ddr_bridge_config.svh"

module app_cmd_sequencer (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      init_calib_complete_i,
  // Queue head
  input  logic                      head_valid_i,
  input  logic                      head_write_i,
  input  ddr_bridge_pkg::app_addr_t head_addr_i,
  input  ddr_bridge_pkg::app_data_t head_wdata_i,
  output logic                      pop_o,
  // Command channel
  output logic                      app_en_o,
  output ddr_bridge_pkg::app_cmd_t  app_cmd_o,
  output ddr_bridge_pkg::app_addr_t app_addr_o,
  input  logic                      app_rdy_i,
  // Write-data channel
  output logic                      app_wdf_wren_o,
  output ddr_bridge_pkg::app_data_t app_wdf_data_o,
  output logic                      app_wdf_end_o,
  input  logic                      app_wdf_rdy_i,
  // Return buffer
  input  logic                      slot_free_i
);

  import ddr_bridge_pkg::*;

  localparam int rsv_width = $clog2(`DDR_RD_BUF_DEPTH + 1);

  seq_state_t state_q;
  seq_state_t state_d;

  // Per-channel acceptance flags, only meaningful in issue
  logic cmd_done_q;
  logic data_done_q;

  logic cmd_fire;
  logic data_fire;
  logic cmd_ok;
  logic data_ok;

  logic [rsv_width-1:0] rsv_count_q;
  logic                 rsv_avail;
  logic                 rd_issue;

  // ******************************
  // Application outputs
  // ******************************
  // Head stays put until the pop, so it can drive the bus directly
  assign app_en_o       = (state_q == issue) && !cmd_done_q;
  assign app_cmd_o      = head_write_i ? app_cmd_write : app_cmd_read;
  assign app_addr_o     = head_addr_i;
  assign app_wdf_wren_o = (state_q == issue) && head_write_i && !data_done_q;
  assign app_wdf_data_o = head_wdata_i;
  // Single beat per write
  assign app_wdf_end_o  = app_wdf_wren_o;

  assign cmd_fire  = app_en_o && app_rdy_i;
  assign data_fire = app_wdf_wren_o && app_wdf_rdy_i;
  assign cmd_ok    = cmd_done_q || cmd_fire;
  assign data_ok   = !head_write_i || data_done_q || data_fire;

  assign pop_o = (state_q == done_pop);

  // A read only starts when a return slot is free
  assign rsv_avail = (rsv_count_q < rsv_width'(`DDR_RD_BUF_DEPTH));
  assign rd_issue  = cmd_fire && !head_write_i;

  // ******************************
  // Next state
  // ******************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      wait_calib: begin
        if (init_calib_complete_i) begin
          state_d = idle;
        end
      end
      idle: begin
        if (head_valid_i && (head_write_i || rsv_avail)) begin
          state_d = issue;
        end
      end
      issue: begin
        if (cmd_ok && data_ok) begin
          state_d = done_pop;
        end
      end
      done_pop: begin
        state_d = idle;
      end
      default: begin
        state_d = wait_calib;
      end
    endcase
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      state_q     <= wait_calib;
      cmd_done_q  <= 1'b0;
      data_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q != issue) begin
        cmd_done_q  <= 1'b0;
        data_done_q <= 1'b0;
      end else begin
        // Channels complete on their own readies
        if (cmd_fire) begin
          cmd_done_q <= 1'b1;
        end
        if (data_fire) begin
          data_done_q <= 1'b1;
        end
      end
    end
  end

  // Reservations: up on read issue, down when the buffer sends a beat
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      rsv_count_q <= '0;
    end else begin
      case ({rd_issue, slot_free_i})
        2'b10:   rsv_count_q <= rsv_count_q + 1'b1;
        2'b01:   rsv_count_q <= rsv_count_q - 1'b1;
        default: rsv_count_q <= rsv_count_q;
      endcase
    end
  end

endmodule

//--- rd_return_buffer.sv
// Read data return FIFO with the response credit counter toward the host
`include "ddr_bridge_config.svh"

module rd_return_buffer (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  // Read data from the controller
  input  ddr_bridge_pkg::app_data_t app_rd_data_i,
  input  logic                      app_rd_data_valid_i,
  // Host response
  input  logic                      rsp_credit_i,
  output logic                      rsp_valid_o,
  output ddr_bridge_pkg::app_data_t rsp_data_o,
  // Slot release to the sequencer
  output logic                      slot_free_o
);

  import ddr_bridge_pkg::*;

  localparam int depth      = `DDR_RD_BUF_DEPTH;
  localparam int ptr_width  = (depth > 1) ? $clog2(depth) : 1;
  localparam int crd_width  = $clog2(`DDR_RSP_CREDITS + 1);

  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [ptr_width:0]   count_q;
  logic [crd_width-1:0] credit_q;

  app_data_t data_mem [depth];

  logic send;

  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // One beat per cycle while a credit is held
  assign send        = (count_q != '0) && (credit_q != '0);
  assign rsp_valid_o = send;
  assign rsp_data_o  = data_mem[rd_ptr_q];
  assign slot_free_o = send;

  // ******************************
  // FIFO control
  // ******************************
  // No overflow check, the sequencer reserved a slot for every read
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (app_rd_data_valid_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (send) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({app_rd_data_valid_i, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (app_rd_data_valid_i) begin
      data_mem[wr_ptr_q] <= app_rd_data_i;
    end
  end

  // Response credits, a send and a return in one cycle cancel
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      credit_q <= crd_width'(`DDR_RSP_CREDITS);
    end else begin
      case ({send, rsp_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

//--- ddr_host_bridge.sv
// Top level of the host to DDR4 application interface bridge: request
// queue, command sequencer and read return buffer
`include "ddr_bridge_config.svh"

module ddr_host_bridge (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  // Host requests
  input  logic                      req_valid_i,
  input  logic                      req_write_i,
  input  ddr_bridge_pkg::app_addr_t req_addr_i,
  input  ddr_bridge_pkg::app_data_t req_wdata_i,
  output logic                      req_credit_o,
  // Host responses
  input  logic                      rsp_credit_i,
  output logic                      rsp_valid_o,
  output ddr_bridge_pkg::app_data_t rsp_data_o,
  // Controller status
  input  logic                      init_calib_complete_i,
  // Command channel
  output logic                      app_en_o,
  output ddr_bridge_pkg::app_cmd_t  app_cmd_o,
  output ddr_bridge_pkg::app_addr_t app_addr_o,
  input  logic                      app_rdy_i,
  // Write-data channel
  output logic                      app_wdf_wren_o,
  output ddr_bridge_pkg::app_data_t app_wdf_data_o,
  output logic                      app_wdf_end_o,
  input  logic                      app_wdf_rdy_i,
  // Read-data channel
  input  ddr_bridge_pkg::app_data_t app_rd_data_i,
  input  logic                      app_rd_data_valid_i
);

  import ddr_bridge_pkg::*;

  // ******************************
  // Queue head and slot wiring
  // ******************************
  logic      head_valid;
  logic      head_write;
  app_addr_t head_addr;
  app_data_t head_wdata;
  logic      pop;
  logic      slot_free;

  req_queue #(
    .DEPTH (`DDR_REQ_DEPTH)
  ) u_req_queue (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_write_o (head_write),
    .head_addr_o  (head_addr),
    .head_wdata_o (head_wdata),
    .req_credit_o (req_credit_o)
  );

  app_cmd_sequencer u_app_cmd_sequencer (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset_i),
    .init_calib_complete_i (init_calib_complete_i),
    .head_valid_i          (head_valid),
    .head_write_i          (head_write),
    .head_addr_i           (head_addr),
    .head_wdata_i          (head_wdata),
    .pop_o                 (pop),
    .app_en_o              (app_en_o),
    .app_cmd_o             (app_cmd_o),
    .app_addr_o            (app_addr_o),
    .app_rdy_i             (app_rdy_i),
    .app_wdf_wren_o        (app_wdf_wren_o),
    .app_wdf_data_o        (app_wdf_data_o),
    .app_wdf_end_o         (app_wdf_end_o),
    .app_wdf_rdy_i         (app_wdf_rdy_i),
    .slot_free_i           (slot_free)
  );

  // Read data goes straight from the controller ports into the buffer
  rd_return_buffer u_rd_return_buffer (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .reset_i             (reset_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .rsp_credit_i        (rsp_credit_i),
    .rsp_valid_o         (rsp_valid_o),
    .rsp_data_o          (rsp_data_o),
    .slot_free_o         (slot_free)
  );

endmodule

//--- tb_clk_gen.sv
// Testbench clock and power-on reset generator
module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic c0_ddr4_clk,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #(PERIOD_NS / 2) c0_ddr4_clk = ~c0_ddr4_clk;
  end

  // Released just after an edge, like the rest of the stimulus
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge c0_ddr4_clk);
    #1 reset_o = 1'b0;
  end

endmodule

//--- tb_ddr_app_model.sv
// Behavioral DDR4 application interface: calibration delay, random readies,
// fixed read latency and a sparse backing memory
`include "ddr_bridge_config.svh"

module tb_ddr_app_model #(
  parameter int CALIB_CYCLES = 20,
  parameter int RD_LATENCY   = 6
) (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  output logic                      init_calib_complete_o,
  input  logic                      app_en_i,
  input  ddr_bridge_pkg::app_cmd_t  app_cmd_i,
  input  ddr_bridge_pkg::app_addr_t app_addr_i,
  output logic                      app_rdy_o,
  input  logic                      app_wdf_wren_i,
  input  ddr_bridge_pkg::app_data_t app_wdf_data_i,
  output logic                      app_wdf_rdy_o,
  output ddr_bridge_pkg::app_data_t app_rd_data_o,
  output logic                      app_rd_data_valid_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import ddr_bridge_pkg::*;

  app_data_t mem [app_addr_t];
  app_data_t rd_data_q [$];
  int        rd_due_q [$];
  int        cycle;
  int        calib_count;
  logic      in_reset;
  logic      cmd_pend;
  logic      data_pend;
  app_addr_t pend_addr;
  app_data_t pend_data;

  // Unwritten locations read as zero
  function automatic app_data_t peek(input app_addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return '0;
  endfunction

  function automatic int entries();
    return mem.num();
  endfunction

  initial begin
    init_calib_complete_o = 1'b0;
    app_rdy_o             = 1'b0;
    app_wdf_rdy_o         = 1'b0;
    app_rd_data_o         = '0;
    app_rd_data_valid_o   = 1'b0;
    cycle                 = 0;
    calib_count           = 0;
    cmd_pend              = 1'b0;
    data_pend             = 1'b0;
  end

  // ******************************
  // Transfers, taken mid-cycle
  // ******************************
  always @(negedge c0_ddr4_clk) begin
    if (!reset_i) begin
      if (app_en_i && app_rdy_o) begin
        if (app_cmd_i == 3'd1) begin
          // Data is fixed at command time
          rd_data_q.push_back(peek(app_addr_i));
          rd_due_q.push_back(cycle + RD_LATENCY);
        end else begin
          cmd_pend  = 1'b1;
          pend_addr = app_addr_i;
        end
      end
      if (app_wdf_wren_i && app_wdf_rdy_o) begin
        data_pend = 1'b1;
        pend_data = app_wdf_data_i;
      end
      // Commit once address and data are both in
      if (cmd_pend && data_pend) begin
        mem[pend_addr] = pend_data;
        cmd_pend       = 1'b0;
        data_pend      = 1'b0;
      end
    end
  end

  // Outputs change shortly after the rising edge
  always @(posedge c0_ddr4_clk) begin
    in_reset = reset_i;
    #1;
    app_rd_data_valid_o = 1'b0;
    if (in_reset) begin
      cycle                 = 0;
      calib_count           = 0;
      init_calib_complete_o = 1'b0;
      app_rdy_o             = 1'b0;
      app_wdf_rdy_o         = 1'b0;
      rd_data_q.delete();
      rd_due_q.delete();
    end else begin
      cycle++;
      if (calib_count < CALIB_CYCLES) begin
        calib_count++;
      end
      init_calib_complete_o = (calib_count >= CALIB_CYCLES);
      app_rdy_o             = ($urandom % 3) != 0;
      app_wdf_rdy_o         = ($urandom % 3) != 0;
      if (rd_due_q.size() > 0 && rd_due_q[0] == cycle) begin
        app_rd_data_valid_o = 1'b1;
        app_rd_data_o       = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end
    end
  end

endmodule

//--- tb_checker.sv
// Bridge monitor: reset and calibration rules, credit accounting, command
// and write delivery, and read data against a reference memory
`include "ddr_bridge_config.svh"

module tb_checker (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      req_valid_i,
  input  logic                      req_write_i,
  input  ddr_bridge_pkg::app_addr_t req_addr_i,
  input  ddr_bridge_pkg::app_data_t req_wdata_i,
  input  logic                      req_credit_i,
  input  logic                      rsp_credit_i,
  input  logic                      rsp_valid_i,
  input  ddr_bridge_pkg::app_data_t rsp_data_i,
  input  logic                      init_calib_complete_i,
  input  logic                      app_en_i,
  input  ddr_bridge_pkg::app_cmd_t  app_cmd_i,
  input  ddr_bridge_pkg::app_addr_t app_addr_i,
  input  logic                      app_rdy_i,
  input  logic                      app_wdf_wren_i,
  input  ddr_bridge_pkg::app_data_t app_wdf_data_i,
  input  logic                      app_wdf_end_i,
  input  logic                      app_wdf_rdy_i,
  output int                        ctrl_err_o,
  output int                        data_err_o,
  output int                        credit_err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import ddr_bridge_pkg::*;

  // Reference state, in host acceptance order
  app_data_t ref_mem [app_addr_t];
  logic      cmd_write_q [$];
  app_addr_t cmd_addr_q [$];
  app_data_t wdata_exp_q [$];
  app_data_t rd_exp_q [$];

  int        req_count;
  int        credit_count;
  int        done_count;
  int        rsp_count;
  int        rsp_credit_count;
  logic      wr_cmd_seen;
  logic      wr_data_seen;
  logic      exp_write;
  app_addr_t exp_addr;
  app_data_t exp_data;
  app_cmd_t  exp_cmd;

  initial begin
    ctrl_err_o       = 0;
    data_err_o       = 0;
    credit_err_o     = 0;
    req_count        = 0;
    credit_count     = 0;
    done_count       = 0;
    rsp_count        = 0;
    rsp_credit_count = 0;
    wr_cmd_seen      = 1'b0;
    wr_data_seen     = 1'b0;
  end

  function automatic app_data_t ref_read(input app_addr_t addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return '0;
  endfunction

  // kind: 0 control, 1 data, 2 credit
  task automatic flag_error(input int kind, input string msg);
    $display("FAILED @ %0d ns: %s", $time, msg);
    case (kind)
      0:       ctrl_err_o++;
      1:       data_err_o++;
      default: credit_err_o++;
    endcase
  endtask

  // ******************************
  // Per-cycle checks, mid-cycle
  // ******************************
  always @(negedge c0_ddr4_clk) begin
    if (reset_i) begin
      if ({req_credit_i, rsp_valid_i, app_en_i, app_wdf_wren_i, app_wdf_end_i} !== 5'b0) begin
        flag_error(0, "control output not low during reset");
      end
    end else begin
      if (!init_calib_complete_i && (app_en_i || app_wdf_wren_i)) begin
        flag_error(0, "application request before calibration done");
      end
      if (req_valid_i) begin
        req_count++;
        cmd_write_q.push_back(req_write_i);
        cmd_addr_q.push_back(req_addr_i);
        if (req_write_i) begin
          ref_mem[req_addr_i] = req_wdata_i;
          wdata_exp_q.push_back(req_wdata_i);
        end else begin
          rd_exp_q.push_back(ref_read(req_addr_i));
        end
      end
      if (req_credit_i) begin
        credit_count++;
      end
      // A queue slot is only free once its request has left on the bus
      if (credit_count > done_count) begin
        flag_error(2, $sformatf("%0d request credits for %0d completed requests",
                                credit_count, done_count));
      end
      // Responses, credits returned in this cycle count from the next one
      if (rsp_valid_i) begin
        rsp_count++;
        if (rsp_count > `DDR_RSP_CREDITS + rsp_credit_count) begin
          flag_error(2, $sformatf("response %0d sent with %0d credits returned",
                                  rsp_count, rsp_credit_count));
        end
        if (rd_exp_q.size() == 0) begin
          flag_error(1, "response with no outstanding read");
        end else begin
          exp_data = rd_exp_q.pop_front();
          if (rsp_data_i !== exp_data) begin
            flag_error(1, $sformatf("read data %h, expected %h", rsp_data_i, exp_data));
          end
        end
      end
      if (rsp_credit_i) begin
        rsp_credit_count++;
      end
      if (app_en_i && app_rdy_i) begin
        if (cmd_write_q.size() == 0) begin
          flag_error(1, "command accepted with no pending request");
        end else begin
          exp_write = cmd_write_q.pop_front();
          exp_addr  = cmd_addr_q.pop_front();
          exp_cmd   = exp_write ? 3'd0 : 3'd1;
          if (app_cmd_i !== exp_cmd || app_addr_i !== exp_addr) begin
            flag_error(1, $sformatf("command %0d at %h, expected %0d at %h",
                                    app_cmd_i, app_addr_i, exp_cmd, exp_addr));
          end
          if (exp_write) begin
            wr_cmd_seen = 1'b1;
          end else begin
            done_count++;
          end
        end
      end
      if (app_wdf_wren_i && app_wdf_rdy_i) begin
        if (app_wdf_end_i !== 1'b1) begin
          flag_error(0, "write beat without app_wdf_end");
        end
        if (wdata_exp_q.size() == 0) begin
          flag_error(1, "write beat with no pending write");
        end else begin
          exp_data = wdata_exp_q.pop_front();
          if (app_wdf_data_i !== exp_data) begin
            flag_error(1, $sformatf("write data %h, expected %h", app_wdf_data_i, exp_data));
          end
          wr_data_seen = 1'b1;
        end
      end
      // A write is complete once both channels have taken it
      if (wr_cmd_seen && wr_data_seen) begin
        done_count++;
        wr_cmd_seen  = 1'b0;
        wr_data_seen = 1'b0;
      end
    end
  end

  task automatic compare_mem(input app_addr_t addr, input app_data_t model_val);
    if (model_val !== ref_read(addr)) begin
      flag_error(1, $sformatf("memory at %h holds %h, expected %h",
                              addr, model_val, ref_read(addr)));
    end
  endtask

  // ******************************
  // End of run
  // ******************************
  task automatic check_end(input int model_entries);
    if (credit_count != req_count) begin
      flag_error(2, $sformatf("%0d request credits for %0d requests",
                              credit_count, req_count));
    end
    if (cmd_write_q.size() != 0 || wdata_exp_q.size() != 0 || rd_exp_q.size() != 0) begin
      flag_error(1, "requests left without a command, write beat or response");
    end
    if (model_entries != ref_mem.num()) begin
      flag_error(1, $sformatf("model holds %0d locations, expected %0d",
                              model_entries, ref_mem.num()));
    end
  endtask

endmodule

//--- tb_ddr_host_bridge.sv
// Testbench top: seeded random host traffic, the bridge, the application
// model, the checker and the run timeout
`include "ddr_bridge_config.svh"

module tb_ddr_host_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  import ddr_bridge_pkg::*;

  localparam int num_requests   = 400;
  localparam int rand_seed      = 93093;
  localparam int addr_pool      = 16;
  localparam int timeout_cycles = num_requests * 40 + 500;

  logic      c0_ddr4_clk;
  logic      reset;
  logic      req_valid;
  logic      req_write;
  logic      req_credit;
  app_addr_t req_addr;
  app_data_t req_wdata;
  logic      rsp_credit;
  logic      rsp_valid;
  app_data_t rsp_data;
  logic      init_calib_complete;
  logic      app_en;
  logic      app_rdy;
  app_cmd_t  app_cmd;
  app_addr_t app_addr;
  logic      app_wdf_wren;
  logic      app_wdf_end;
  logic      app_wdf_rdy;
  app_data_t app_wdf_data;
  app_data_t app_rd_data;
  logic      app_rd_data_valid;
  int        ctrl_errs;
  int        data_errs;
  int        credit_errs;

  // Host side bookkeeping
  int host_credits = `DDR_REQ_DEPTH;
  int owed_credits = 0;
  int credit_hold  = 0;
  int sent         = 0;
  int reads_sent   = 0;
  int rsp_seen     = 0;
  int cycle_count  = 0;

  tb_clk_gen clk_gen0 (
    .c0_ddr4_clk (c0_ddr4_clk),
    .reset_o     (reset)
  );

  ddr_host_bridge dut0 (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset),
    .req_valid_i           (req_valid),
    .req_write_i           (req_write),
    .req_addr_i            (req_addr),
    .req_wdata_i           (req_wdata),
    .req_credit_o          (req_credit),
    .rsp_credit_i          (rsp_credit),
    .rsp_valid_o           (rsp_valid),
    .rsp_data_o            (rsp_data),
    .init_calib_complete_i (init_calib_complete),
    .app_en_o              (app_en),
    .app_cmd_o             (app_cmd),
    .app_addr_o            (app_addr),
    .app_rdy_i             (app_rdy),
    .app_wdf_wren_o        (app_wdf_wren),
    .app_wdf_data_o        (app_wdf_data),
    .app_wdf_end_o         (app_wdf_end),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .app_rd_data_i         (app_rd_data),
    .app_rd_data_valid_i   (app_rd_data_valid)
  );

  tb_ddr_app_model model0 (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset),
    .init_calib_complete_o (init_calib_complete),
    .app_en_i              (app_en),
    .app_cmd_i             (app_cmd),
    .app_addr_i            (app_addr),
    .app_rdy_o             (app_rdy),
    .app_wdf_wren_i        (app_wdf_wren),
    .app_wdf_data_i        (app_wdf_data),
    .app_wdf_rdy_o         (app_wdf_rdy),
    .app_rd_data_o         (app_rd_data),
    .app_rd_data_valid_o   (app_rd_data_valid)
  );

  tb_checker chk0 (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .reset_i               (reset),
    .req_valid_i           (req_valid),
    .req_write_i           (req_write),
    .req_addr_i            (req_addr),
    .req_wdata_i           (req_wdata),
    .req_credit_i          (req_credit),
    .rsp_credit_i          (rsp_credit),
    .rsp_valid_i           (rsp_valid),
    .rsp_data_i            (rsp_data),
    .init_calib_complete_i (init_calib_complete),
    .app_en_i              (app_en),
    .app_cmd_i             (app_cmd),
    .app_addr_i            (app_addr),
    .app_rdy_i             (app_rdy),
    .app_wdf_wren_i        (app_wdf_wren),
    .app_wdf_data_i        (app_wdf_data),
    .app_wdf_end_i         (app_wdf_end),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .ctrl_err_o            (ctrl_errs),
    .data_err_o            (data_errs),
    .credit_err_o          (credit_errs)
  );

  // Small address pool so that reads hit earlier writes
  function automatic app_addr_t pool_addr(input int idx);
    return app_addr_t'(32'h0040_0000 + idx * 32'h0001_1040);
  endfunction

  task automatic send_request();
    req_valid = 1'b1;
    req_write = ($urandom % 2) == 1;
    req_addr  = pool_addr($urandom_range(addr_pool - 1, 0));
    req_wdata = {$urandom, $urandom};
    host_credits--;
    sent++;
    if (!req_write) begin
      reads_sent++;
    end
  endtask

  task automatic return_rsp_credit();
    if (credit_hold > 0) begin
      credit_hold--;
    end else if (($urandom % 256) == 0) begin
      // Long gap, so the return buffer fills and the reservations run out
      credit_hold = $urandom_range(250, 100);
    end else if (owed_credits > 0 && ($urandom % 3) == 0) begin
      rsp_credit = 1'b1;
      owed_credits--;
    end
  endtask

  task automatic print_counts();
    $display("Error counts: control %0d, data %0d, credit %0d, total %0d",
             ctrl_errs, data_errs, credit_errs, ctrl_errs + data_errs + credit_errs);
  endtask

  // Credits and responses as the host sees them
  always @(negedge c0_ddr4_clk) begin
    if (req_credit) begin
      host_credits++;
    end
    if (rsp_valid) begin
      rsp_seen++;
      owed_credits++;
    end
  end

  always @(posedge c0_ddr4_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles: %0d of %0d requests sent, %0d of %0d reads answered",
               cycle_count, sent, num_requests, rsp_seen, reads_sent);
      print_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ******************************
  // Stimulus
  // ******************************
  initial begin
    void'($urandom(rand_seed));
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_credit = 1'b0;
    @(negedge reset);
    // Keep going until all traffic is answered and every credit is home
    while (sent < num_requests || rsp_seen < reads_sent ||
           host_credits != `DDR_REQ_DEPTH || owed_credits > 0) begin
      @(posedge c0_ddr4_clk);
      #1;
      req_valid  = 1'b0;
      rsp_credit = 1'b0;
      return_rsp_credit();
      if (sent < num_requests && host_credits > 0 && ($urandom % 4) != 0) begin
        send_request();
      end
    end
    @(posedge c0_ddr4_clk);
    #1;
    req_valid  = 1'b0;
    rsp_credit = 1'b0;
    repeat (10) @(posedge c0_ddr4_clk);
    for (int i = 0; i < addr_pool; i++) begin
      chk0.compare_mem(pool_addr(i), model0.peek(pool_addr(i)));
    end
    chk0.check_end(model0.entries());
    print_counts();
    if (ctrl_errs + data_errs + credit_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
ddr_bridge_pkg.sv
req_queue.sv
app_cmd_sequencer.sv
rd_return_buffer.sv
ddr_host_bridge.sv
tb_clk_gen.sv
tb_ddr_app_model.sv
tb_checker.sv
tb_ddr_host_bridge.sv

//--- Bender.yml
package:
  name: ddr_host_bridge

sources:
  - include_dirs:
      - .
    files:
      - ddr_bridge_pkg.sv
      - req_queue.sv
      - app_cmd_sequencer.sv
      - rd_return_buffer.sv
      - ddr_host_bridge.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_ddr_app_model.sv
      - tb_checker.sv
      - tb_ddr_host_bridge.sv
